// File: verilog/kiwi_pkg.sv
`default_nettype none

package kiwi_pkg;

    typedef logic [63:0] xlen_t;
    typedef logic [63:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [7:0]  strb_t;
    typedef logic [2:0]  prot_t;
    typedef logic [1:0]  resp_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS
    } alu_op_e;

    typedef enum logic [1:0] {
        KIND_ALU,
        KIND_STORE,
        KIND_HALT,
        KIND_NOP
    } op_kind_e;

    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // unprivileged, secure; instruction side sets bit 2
    localparam prot_t AXI_PROT_DATA = 3'b000;
    localparam prot_t AXI_PROT_INST = 3'b100;

    typedef enum logic [1:0] {
        FETCH_ADDR,
        FETCH_DATA,
        FETCH_HOLD
    } fetch_state_e;

    typedef enum logic [1:0] {
        STORE_IDLE,
        STORE_SEND,
        STORE_RESP
    } store_state_e;

endpackage

`default_nettype wire

// File: verilog/kiwi_if.sv
`timescale 1ns/10ps
`default_nettype none

// fetched instruction towards decode
interface inst_if;
    logic            valid;
    kiwi_pkg::addr_t pc;
    kiwi_pkg::inst_t inst;
    logic            stall;

    modport producer (output valid, output pc, output inst, input stall);
    modport consumer (input valid, input pc, input inst, output stall);
endinterface

// decoded operation towards execute
interface op_if;
    logic               valid;
    kiwi_pkg::op_kind_e kind;
    kiwi_pkg::alu_op_e  alu_op;
    logic               use_imm;
    kiwi_pkg::reg_idx_t rd;
    kiwi_pkg::reg_idx_t rs1;
    kiwi_pkg::reg_idx_t rs2;
    kiwi_pkg::xlen_t    imm;
    kiwi_pkg::addr_t    pc;
    logic [2:0]         size;
    logic               stall;

    modport producer (
        output valid, output kind, output alu_op, output use_imm, output rd,
        output rs1, output rs2, output imm, output pc, output size, input stall
    );
    modport consumer (
        input valid, input kind, input alu_op, input use_imm, input rd,
        input rs1, input rs2, input imm, input pc, input size, output stall
    );
endinterface

// lane-aligned store towards the write channel
interface store_if;
    logic            valid;
    kiwi_pkg::addr_t addr;
    kiwi_pkg::xlen_t data;
    kiwi_pkg::strb_t strb;
    logic            stall;

    modport producer (output valid, output addr, output data, output strb, input stall);
    modport consumer (input valid, input addr, input data, input strb, output stall);
endinterface

`default_nettype wire

// File: verilog/fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_unit #(
    parameter kiwi_pkg::addr_t RESET_VEC = '0
) (
    input  wire                   clk_i,
    input  wire                   rst_n_i,
    output logic                  arvalid_o,
    output kiwi_pkg::addr_t       araddr_o,
    input  wire                   arready_i,
    input  wire                   rvalid_i,
    input  wire kiwi_pkg::xlen_t  rdata_i,
    output logic                  rready_o,
    inst_if.producer              inst_o
);

    kiwi_pkg::fetch_state_e state_q;
    kiwi_pkg::addr_t        pc_q;
    kiwi_pkg::inst_t        inst_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= kiwi_pkg::FETCH_ADDR;
            pc_q    <= RESET_VEC;
        end else begin
            case (state_q)
                kiwi_pkg::FETCH_ADDR: begin
                    if (arready_i) begin
                        state_q <= kiwi_pkg::FETCH_DATA;
                    end
                end
                kiwi_pkg::FETCH_DATA: begin
                    if (rvalid_i) begin
                        state_q <= kiwi_pkg::FETCH_HOLD;
                    end
                end
                kiwi_pkg::FETCH_HOLD: begin
                    // next read goes out once decode takes this one
                    if (!inst_o.stall) begin
                        pc_q    <= pc_q + 64'd4;
                        state_q <= kiwi_pkg::FETCH_ADDR;
                    end
                end
                default: begin
                    state_q <= kiwi_pkg::FETCH_ADDR;
                end
            endcase
        end
    end

    // pick the addressed half of the 64-bit beat
    always_ff @(posedge clk_i) begin
        if (state_q == kiwi_pkg::FETCH_DATA && rvalid_i) begin
            inst_q <= pc_q[2] ? rdata_i[63:32] : rdata_i[31:0];
        end
    end

    assign arvalid_o = (state_q == kiwi_pkg::FETCH_ADDR);
    assign araddr_o  = pc_q;
    assign rready_o  = (state_q == kiwi_pkg::FETCH_DATA);

    assign inst_o.valid = (state_q == kiwi_pkg::FETCH_HOLD);
    assign inst_o.pc    = pc_q;
    assign inst_o.inst  = inst_q;

endmodule

`default_nettype wire

// File: verilog/inst_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module inst_decoder (
    inst_if.consumer inst_i,
    op_if.producer   op_o
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            alt;
    kiwi_pkg::xlen_t imm_i;
    kiwi_pkg::xlen_t imm_s;
    kiwi_pkg::xlen_t imm_u;

    assign opcode = inst_i.inst[6:0];
    assign funct3 = inst_i.inst[14:12];
    // bit 30 selects sub and sra; for op-imm only srai uses it
    assign alt = inst_i.inst[30] & ((opcode == kiwi_pkg::OPC_OP) | (funct3 == 3'b101));

    assign imm_i = {{52{inst_i.inst[31]}}, inst_i.inst[31:20]};
    assign imm_s = {{52{inst_i.inst[31]}}, inst_i.inst[31:25], inst_i.inst[11:7]};
    assign imm_u = {{32{inst_i.inst[31]}}, inst_i.inst[31:12], 12'b0};

    always_comb begin
        op_o.kind    = kiwi_pkg::KIND_NOP;
        op_o.alu_op  = kiwi_pkg::ALU_ADD;
        op_o.use_imm = 1'b0;
        op_o.imm     = imm_i;
        case (opcode)
            kiwi_pkg::OPC_OP_IMM, kiwi_pkg::OPC_OP: begin
                op_o.kind    = kiwi_pkg::KIND_ALU;
                op_o.use_imm = (opcode == kiwi_pkg::OPC_OP_IMM);
                case (funct3)
                    3'b000:  op_o.alu_op = alt ? kiwi_pkg::ALU_SUB : kiwi_pkg::ALU_ADD;
                    3'b001:  op_o.alu_op = kiwi_pkg::ALU_SLL;
                    3'b010:  op_o.alu_op = kiwi_pkg::ALU_SLT;
                    3'b011:  op_o.alu_op = kiwi_pkg::ALU_SLTU;
                    3'b100:  op_o.alu_op = kiwi_pkg::ALU_XOR;
                    3'b101:  op_o.alu_op = alt ? kiwi_pkg::ALU_SRA : kiwi_pkg::ALU_SRL;
                    3'b110:  op_o.alu_op = kiwi_pkg::ALU_OR;
                    default: op_o.alu_op = kiwi_pkg::ALU_AND;
                endcase
            end
            kiwi_pkg::OPC_LUI, kiwi_pkg::OPC_AUIPC: begin
                // use_imm low makes the passed immediate pc-relative
                op_o.kind    = kiwi_pkg::KIND_ALU;
                op_o.alu_op  = kiwi_pkg::ALU_PASS;
                op_o.use_imm = (opcode == kiwi_pkg::OPC_LUI);
                op_o.imm     = imm_u;
            end
            kiwi_pkg::OPC_STORE: begin
                op_o.kind = kiwi_pkg::KIND_STORE;
                op_o.imm  = imm_s;
            end
            kiwi_pkg::OPC_SYSTEM: begin
                // only ebreak, the rest of system is a nop
                if (funct3 == 3'b000 && inst_i.inst[31:20] == 12'h001) begin
                    op_o.kind = kiwi_pkg::KIND_HALT;
                end
            end
            default: begin
                op_o.kind = kiwi_pkg::KIND_NOP;
            end
        endcase
    end

    assign op_o.valid   = inst_i.valid;
    assign op_o.rd      = inst_i.inst[11:7];
    assign op_o.rs1     = inst_i.inst[19:15];
    assign op_o.rs2     = inst_i.inst[24:20];
    assign op_o.pc      = inst_i.pc;
    assign op_o.size    = funct3;
    assign inst_i.stall = op_o.stall;

endmodule

`default_nettype wire

// File: verilog/int_execute.sv
`timescale 1ns/10ps
`default_nettype none

module int_execute (
    input  wire        clk_i,
    input  wire        rst_n_i,
    op_if.consumer     op_i,
    store_if.producer  store_o,
    output logic       halt_o
);

    kiwi_pkg::xlen_t regs [31:0];
    kiwi_pkg::xlen_t rs1_val;
    kiwi_pkg::xlen_t rs2_val;
    kiwi_pkg::xlen_t src_b;
    kiwi_pkg::xlen_t alu_res;
    logic [5:0]      shamt;
    kiwi_pkg::addr_t st_addr;
    kiwi_pkg::strb_t st_strb;
    logic            needs_store;
    logic            accept;
    logic            halted_q;

    // x0 is never written
    assign rs1_val = (op_i.rs1 == '0) ? '0 : regs[op_i.rs1];
    assign rs2_val = (op_i.rs2 == '0) ? '0 : regs[op_i.rs2];
    assign src_b   = op_i.use_imm ? op_i.imm : rs2_val;
    assign shamt   = src_b[5:0];

    always_comb begin
        case (op_i.alu_op)
            kiwi_pkg::ALU_ADD:  alu_res = rs1_val + src_b;
            kiwi_pkg::ALU_SUB:  alu_res = rs1_val - src_b;
            kiwi_pkg::ALU_SLL:  alu_res = rs1_val << shamt;
            kiwi_pkg::ALU_SLT:  alu_res = {63'b0, $signed(rs1_val) < $signed(src_b)};
            kiwi_pkg::ALU_SLTU: alu_res = {63'b0, rs1_val < src_b};
            kiwi_pkg::ALU_XOR:  alu_res = rs1_val ^ src_b;
            kiwi_pkg::ALU_SRL:  alu_res = rs1_val >> shamt;
            kiwi_pkg::ALU_SRA:  alu_res = $signed(rs1_val) >>> shamt;
            kiwi_pkg::ALU_OR:   alu_res = rs1_val | src_b;
            kiwi_pkg::ALU_AND:  alu_res = rs1_val & src_b;
            // lui passes imm, auipc adds the pc
            kiwi_pkg::ALU_PASS: alu_res = op_i.use_imm ? op_i.imm : op_i.pc + op_i.imm;
            default:            alu_res = rs1_val + src_b;
        endcase
    end

    // store address, then data and strobes moved onto their byte lanes
    assign st_addr = rs1_val + op_i.imm;

    always_comb begin
        case (op_i.size[1:0])
            2'b00:   st_strb = 8'h01;
            2'b01:   st_strb = 8'h03;
            2'b10:   st_strb = 8'h0f;
            default: st_strb = 8'hff;
        endcase
    end

    assign store_o.valid = op_i.valid & (op_i.kind == kiwi_pkg::KIND_STORE) & ~halted_q;
    assign store_o.addr  = st_addr;
    assign store_o.data  = rs2_val << {st_addr[2:0], 3'b000};
    assign store_o.strb  = st_strb << st_addr[2:0];

    // ebreak waits for the store buffer to drain as well
    assign needs_store = (op_i.kind == kiwi_pkg::KIND_STORE) | (op_i.kind == kiwi_pkg::KIND_HALT);
    assign op_i.stall  = halted_q | (needs_store & store_o.stall);
    assign accept      = op_i.valid & ~op_i.stall;

    always_ff @(posedge clk_i) begin
        if (accept && op_i.kind == kiwi_pkg::KIND_ALU && op_i.rd != '0) begin
            regs[op_i.rd] <= alu_res;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            halted_q <= 1'b0;
        end else if (accept && op_i.kind == kiwi_pkg::KIND_HALT) begin
            halted_q <= 1'b1;
        end
    end

    assign halt_o = halted_q;

endmodule

`default_nettype wire

// File: verilog/store_unit.sv
`timescale 1ns/10ps
`default_nettype none

module store_unit (
    input  wire                  clk_i,
    input  wire                  rst_n_i,
    store_if.consumer            store_i,
    output logic                 awvalid_o,
    output kiwi_pkg::addr_t      awaddr_o,
    input  wire                  awready_i,
    output logic                 wvalid_o,
    output kiwi_pkg::xlen_t      wdata_o,
    output kiwi_pkg::strb_t      wstrb_o,
    input  wire                  wready_i,
    input  wire                  bvalid_i,
    output logic                 bready_o
);

    kiwi_pkg::store_state_e state_q;
    logic                   aw_done_q;
    logic                   w_done_q;
    logic                   aw_fire;
    logic                   w_fire;
    kiwi_pkg::addr_t        addr_q;
    kiwi_pkg::xlen_t        data_q;
    kiwi_pkg::strb_t        strb_q;

    assign aw_fire = awvalid_o & awready_i;
    assign w_fire  = wvalid_o & wready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= kiwi_pkg::STORE_IDLE;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
        end else begin
            case (state_q)
                kiwi_pkg::STORE_IDLE: begin
                    if (store_i.valid) begin
                        state_q   <= kiwi_pkg::STORE_SEND;
                        aw_done_q <= 1'b0;
                        w_done_q  <= 1'b0;
                    end
                end
                kiwi_pkg::STORE_SEND: begin
                    // address and data complete independently
                    aw_done_q <= aw_done_q | aw_fire;
                    w_done_q  <= w_done_q | w_fire;
                    if ((aw_done_q | aw_fire) && (w_done_q | w_fire)) begin
                        state_q <= kiwi_pkg::STORE_RESP;
                    end
                end
                kiwi_pkg::STORE_RESP: begin
                    if (bvalid_i) begin
                        state_q <= kiwi_pkg::STORE_IDLE;
                    end
                end
                default: begin
                    state_q <= kiwi_pkg::STORE_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == kiwi_pkg::STORE_IDLE && store_i.valid) begin
            addr_q <= store_i.addr;
            data_q <= store_i.data;
            strb_q <= store_i.strb;
        end
    end

    assign store_i.stall = (state_q != kiwi_pkg::STORE_IDLE);

    assign awvalid_o = (state_q == kiwi_pkg::STORE_SEND) & ~aw_done_q;
    assign awaddr_o  = addr_q;
    assign wvalid_o  = (state_q == kiwi_pkg::STORE_SEND) & ~w_done_q;
    assign wdata_o   = data_q;
    assign wstrb_o   = strb_q;
    assign bready_o  = (state_q == kiwi_pkg::STORE_RESP);

endmodule

`default_nettype wire

// File: verilog/kiwi_core.sv
`timescale 1ns/10ps
`default_nettype none

module kiwi_core #(
    parameter kiwi_pkg::addr_t RESET_VEC = '0
) (
    input  wire                   clk_i,
    input  wire                   rst_n_i,
    // instruction read channel
    output logic                  arvalid_o,
    output kiwi_pkg::addr_t       araddr_o,
    output kiwi_pkg::prot_t       arprot_o,
    input  wire                   arready_i,
    input  wire                   rvalid_i,
    input  wire kiwi_pkg::xlen_t  rdata_i,
    input  wire kiwi_pkg::resp_t  rresp_i,
    output logic                  rready_o,
    // data write channel
    output logic                  awvalid_o,
    output kiwi_pkg::addr_t       awaddr_o,
    output kiwi_pkg::prot_t       awprot_o,
    input  wire                   awready_i,
    output logic                  wvalid_o,
    output kiwi_pkg::xlen_t       wdata_o,
    output kiwi_pkg::strb_t       wstrb_o,
    input  wire                   wready_i,
    input  wire                   bvalid_i,
    input  wire kiwi_pkg::resp_t  bresp_i,
    output logic                  bready_o,
    output logic                  halt_o
);

    inst_if  inst_bus ();
    op_if    op_bus ();
    store_if store_bus ();

    // responses are not checked; every access is assumed to succeed
    assign arprot_o = kiwi_pkg::AXI_PROT_INST;
    assign awprot_o = kiwi_pkg::AXI_PROT_DATA;

    fetch_unit #(
        .RESET_VEC (RESET_VEC)
    ) u_fetch_unit (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .arvalid_o (arvalid_o),
        .araddr_o  (araddr_o),
        .arready_i (arready_i),
        .rvalid_i  (rvalid_i),
        .rdata_i   (rdata_i),
        .rready_o  (rready_o),
        .inst_o    (inst_bus.producer)
    );

    inst_decoder u_inst_decoder (
        .inst_i (inst_bus.consumer),
        .op_o   (op_bus.producer)
    );

    int_execute u_int_execute (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .op_i    (op_bus.consumer),
        .store_o (store_bus.producer),
        .halt_o  (halt_o)
    );

    store_unit u_store_unit (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .store_i   (store_bus.consumer),
        .awvalid_o (awvalid_o),
        .awaddr_o  (awaddr_o),
        .awready_i (awready_i),
        .wvalid_o  (wvalid_o),
        .wdata_o   (wdata_o),
        .wstrb_o   (wstrb_o),
        .wready_i  (wready_i),
        .bvalid_i  (bvalid_i),
        .bready_o  (bready_o)
    );

endmodule

`default_nettype wire

// File: testbench/kiwi_tb.sv
`timescale 1ns/10ps
`default_nettype none

module kiwi_tb;

    localparam kiwi_pkg::addr_t RESET_VEC  = 64'h0;
    localparam int              PROG_WORDS = 64;
    localparam int              WAIT_LIMIT = 2000;
    localparam int              RUN_LIMIT  = 20000;

    logic             clk_i = 1'b0;
    logic             rst_n_i;
    logic             arvalid_o;
    kiwi_pkg::addr_t  araddr_o;
    kiwi_pkg::prot_t  arprot_o;
    logic             arready_i;
    logic             rvalid_i;
    kiwi_pkg::xlen_t  rdata_i;
    kiwi_pkg::resp_t  rresp_i;
    logic             rready_o;
    logic             awvalid_o;
    kiwi_pkg::addr_t  awaddr_o;
    kiwi_pkg::prot_t  awprot_o;
    logic             awready_i;
    logic             wvalid_o;
    kiwi_pkg::xlen_t  wdata_o;
    kiwi_pkg::strb_t  wstrb_o;
    logic             wready_i;
    logic             bvalid_i;
    kiwi_pkg::resp_t  bresp_i;
    logic             bready_o;
    logic             halt_o;

    kiwi_pkg::inst_t  prog [PROG_WORDS];
    int               prog_len = 0;
    kiwi_pkg::addr_t  exp_addr_q [$];
    kiwi_pkg::xlen_t  exp_data_q [$];
    kiwi_pkg::strb_t  exp_strb_q [$];
    int               exp_total = 0;
    int               errors = 0;
    int               stores_checked = 0;
    int               reads_seen = 0;
    int               cycles;

    // bus model state
    kiwi_pkg::addr_t  next_fetch = RESET_VEC;
    kiwi_pkg::addr_t  rd_addr = '0;
    logic             rd_pending = 1'b0;
    kiwi_pkg::addr_t  got_addr = '0;
    kiwi_pkg::xlen_t  got_data = '0;
    kiwi_pkg::strb_t  got_strb = '0;
    logic             aw_seen = 1'b0;
    logic             w_seen = 1'b0;
    logic             aw_stalled = 1'b0;
    logic             w_stalled = 1'b0;
    kiwi_pkg::addr_t  held_awaddr = '0;
    kiwi_pkg::xlen_t  held_wdata = '0;
    kiwi_pkg::strb_t  held_wstrb = '0;
    int unsigned      ar_wait = 0;
    int unsigned      r_wait = 0;
    int unsigned      aw_wait = 0;
    int unsigned      w_wait = 0;
    int unsigned      b_wait = 0;

    kiwi_core #(
        .RESET_VEC (RESET_VEC)
    ) UUT (.*);

    always #5 clk_i = ~clk_i;

    task automatic note_failure(input string what);
        errors++;
        $display("ERROR: %s", what);
    endtask

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp) else begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    function automatic kiwi_pkg::inst_t r_type(input int f7, input int f3, input int rd,
                                               input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], kiwi_pkg::OPC_OP};
    endfunction

    function automatic kiwi_pkg::inst_t i_type(input int f3, input int rd, input int rs1,
                                               input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], kiwi_pkg::OPC_OP_IMM};
    endfunction

    function automatic kiwi_pkg::inst_t s_type(input int f3, input int rs1, input int rs2,
                                               input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], kiwi_pkg::OPC_STORE};
    endfunction

    function automatic kiwi_pkg::inst_t u_type(input logic [6:0] opc, input int rd,
                                               input int imm);
        return {imm[19:0], rd[4:0], opc};
    endfunction

    // words past the program are addi x0 with an address-folded immediate
    function automatic kiwi_pkg::inst_t word_at(input kiwi_pkg::addr_t addr);
        logic [31:0] fold;
        fold = addr[63:32] ^ addr[31:0];
        if (addr[63:2] < 62'(prog_len)) begin
            return prog[addr[7:2]];
        end
        return i_type(0, 0, 0, int'(fold[11:0] ^ fold[23:12] ^ {4'h0, fold[31:24]}));
    endfunction

    function automatic kiwi_pkg::xlen_t beat_at(input kiwi_pkg::addr_t addr);
        kiwi_pkg::addr_t base;
        base = {addr[63:3], 3'b000};
        return {word_at(base + 64'd4), word_at(base)};
    endfunction

    function automatic kiwi_pkg::xlen_t strobe_mask(input kiwi_pkg::strb_t strb);
        kiwi_pkg::xlen_t mask;
        for (int b = 0; b < 8; b++) begin
            mask[b*8 +: 8] = {8{strb[b]}};
        end
        return mask;
    endfunction

    task automatic emit(input kiwi_pkg::inst_t word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    task automatic build_program();
        emit(u_type(kiwi_pkg::OPC_LUI, 1, 'h80000));
        emit(i_type(0, 2, 0, -5));
        emit(i_type(0, 3, 0, 7));
        emit(i_type(1, 4, 3, 40));
        emit(i_type(5, 5, 1, 4));
        emit(i_type(5, 6, 1, 'h404));
        emit(r_type(0, 0, 7, 2, 3));
        emit(r_type(32, 0, 8, 2, 3));
        emit(r_type(0, 1, 9, 3, 3));
        emit(r_type(0, 2, 10, 2, 3));
        emit(r_type(0, 3, 11, 2, 3));
        emit(r_type(0, 4, 12, 1, 2));
        emit(r_type(0, 5, 13, 2, 3));
        emit(r_type(32, 5, 14, 2, 3));
        emit(r_type(0, 6, 15, 1, 3));
        emit(r_type(0, 7, 16, 1, 2));
        emit(i_type(2, 17, 2, 1));
        emit(i_type(3, 18, 3, -1));
        emit(i_type(4, 19, 2, 'h0f0));
        emit(i_type(6, 20, 3, -256));
        emit(i_type(7, 21, 2, 'h7f));
        emit(u_type(kiwi_pkg::OPC_AUIPC, 22, 1));
        // fence falls through as a nop, x0 stays zero
        emit(32'h0000_000f);
        emit(i_type(0, 0, 3, 5));
        emit(i_type(0, 23, 0, 'h200));
        for (int r = 1; r <= 22; r++) begin
            emit(s_type(3, 23, r, (r - 1) * 8));
        end
        emit(s_type(3, 23, 0, 'hb0));
        emit(u_type(kiwi_pkg::OPC_LUI, 24, 'h12345));
        emit(i_type(0, 24, 24, 'h678));
        emit(s_type(0, 23, 24, 'h103));
        emit(s_type(1, 23, 24, 'h10a));
        emit(s_type(2, 23, 24, 'h114));
        emit(32'h0010_0073);
    endtask

    // executes the program from the ISA rules and queues each expected write
    task automatic run_reference();
        kiwi_pkg::xlen_t rf [32];
        kiwi_pkg::addr_t pc;
        kiwi_pkg::inst_t w;
        kiwi_pkg::xlen_t a;
        kiwi_pkg::xlen_t b;
        kiwi_pkg::xlen_t res;
        kiwi_pkg::addr_t ea;
        kiwi_pkg::xlen_t data;
        kiwi_pkg::strb_t strb;
        logic [6:0]      opc;
        logic [2:0]      f3;
        int              sh;
        int              off;
        logic            wr;
        logic            done;
        for (int i = 0; i < 32; i++) begin
            rf[i] = '0;
        end
        pc = RESET_VEC;
        done = 1'b0;
        while (!done && pc[63:2] < 62'(prog_len)) begin
            w = prog[pc[7:2]];
            opc = w[6:0];
            f3 = w[14:12];
            a = rf[w[19:15]];
            b = rf[w[24:20]];
            wr = 1'b0;
            res = '0;
            case (opc)
                kiwi_pkg::OPC_OP_IMM, kiwi_pkg::OPC_OP: begin
                    if (opc == kiwi_pkg::OPC_OP_IMM) begin
                        b = {{52{w[31]}}, w[31:20]};
                    end
                    sh = int'(b[5:0]);
                    wr = 1'b1;
                    case (f3)
                        3'd0: res = (opc == kiwi_pkg::OPC_OP && w[30]) ? a - b : a + b;
                        3'd1: res = a << sh;
                        3'd2: res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
                        3'd3: res = (a < b) ? 64'd1 : 64'd0;
                        3'd4: res = a ^ b;
                        3'd5: res = w[30] ? 64'($signed(a) >>> sh) : a >> sh;
                        3'd6: res = a | b;
                        default: res = a & b;
                    endcase
                end
                kiwi_pkg::OPC_LUI: begin
                    res = {{32{w[31]}}, w[31:12], 12'h000};
                    wr = 1'b1;
                end
                kiwi_pkg::OPC_AUIPC: begin
                    res = pc + {{32{w[31]}}, w[31:12], 12'h000};
                    wr = 1'b1;
                end
                kiwi_pkg::OPC_STORE: begin
                    ea = a + {{52{w[31]}}, w[31:25], w[11:7]};
                    off = int'(ea[2:0]);
                    data = '0;
                    strb = '0;
                    for (int k = 0; k < (1 << f3[1:0]); k++) begin
                        data[(off + k) * 8 +: 8] = b[k * 8 +: 8];
                        strb[off + k] = 1'b1;
                    end
                    exp_addr_q.push_back(ea);
                    exp_data_q.push_back(data);
                    exp_strb_q.push_back(strb);
                end
                kiwi_pkg::OPC_SYSTEM: done = (w == 32'h0010_0073);
                default: wr = 1'b0;
            endcase
            if (wr && w[11:7] != 5'd0) begin
                rf[w[11:7]] = res;
            end
            pc = pc + 64'd4;
        end
        exp_total = exp_addr_q.size();
    endtask

    task automatic compare_store();
        string tag;
        tag = $sformatf("store %0d", stores_checked);
        assert (exp_addr_q.size() != 0) else note_failure("write seen after the last expected store");
        if (exp_addr_q.size() != 0) begin
            check_value({tag, " awaddr"}, exp_addr_q.pop_front(), got_addr);
            check_value({tag, " wdata"}, exp_data_q.pop_front(), got_data & strobe_mask(got_strb));
            check_value({tag, " wstrb"}, 64'(exp_strb_q.pop_front()), 64'(got_strb));
        end
        stores_checked++;
    endtask

    task automatic check_idle_outputs(input string tag);
        check_value(tag, 64'd0, 64'({awvalid_o, wvalid_o, bready_o, rready_o, halt_o}));
    endtask

    // instruction read channel
    always @(posedge clk_i) begin
        if (rst_n_i) begin
            if (rvalid_i && rready_o) begin
                rvalid_i <= 1'b0;
                rd_pending <= 1'b0;
            end else if (rd_pending && !rvalid_i) begin
                if (r_wait == 0) begin
                    rvalid_i <= 1'b1;
                    rdata_i <= beat_at(rd_addr);
                end else begin
                    r_wait <= r_wait - 1;
                end
            end
            if (arvalid_o && arready_i) begin
                assert (!rd_pending) else note_failure("read issued while another is outstanding");
                check_value("fetch address", next_fetch, araddr_o);
                // AxPROT bit 2 marks an instruction access
                check_value("arprot", 64'h4, 64'(arprot_o));
                next_fetch <= next_fetch + 64'd4;
                rd_addr <= araddr_o;
                rd_pending <= 1'b1;
                reads_seen++;
                arready_i <= 1'b0;
                ar_wait <= $urandom_range(4, 0);
                r_wait <= $urandom_range(4, 0);
            end else if (ar_wait != 0) begin
                ar_wait <= ar_wait - 1;
            end else begin
                arready_i <= 1'b1;
            end
        end
    end

    // data write channel, ready only answers a valid that is already waiting
    always @(posedge clk_i) begin
        if (rst_n_i) begin
            if (aw_stalled) begin
                assert (awvalid_o && awaddr_o == held_awaddr)
                    else note_failure("write address dropped or changed before awready");
            end
            if (w_stalled) begin
                assert (wvalid_o && wdata_o == held_wdata && wstrb_o == held_wstrb)
                    else note_failure("write data dropped or changed before wready");
            end
            aw_stalled <= awvalid_o && !awready_i;
            w_stalled <= wvalid_o && !wready_i;
            held_awaddr <= awaddr_o;
            held_wdata <= wdata_o;
            held_wstrb <= wstrb_o;
            if (awvalid_o && awready_i) begin
                assert (!aw_seen) else note_failure("second write address before the response");
                check_value("awprot", 64'h0, 64'(awprot_o));
                got_addr <= awaddr_o;
                aw_seen <= 1'b1;
                awready_i <= 1'b0;
                aw_wait <= $urandom_range(4, 0);
            end else if (awvalid_o && aw_wait != 0) begin
                aw_wait <= aw_wait - 1;
            end else if (awvalid_o) begin
                awready_i <= 1'b1;
            end
            if (wvalid_o && wready_i) begin
                assert (!w_seen) else note_failure("second write data beat before the response");
                got_data <= wdata_o;
                got_strb <= wstrb_o;
                w_seen <= 1'b1;
                wready_i <= 1'b0;
                w_wait <= $urandom_range(4, 0);
            end else if (wvalid_o && w_wait != 0) begin
                w_wait <= w_wait - 1;
            end else if (wvalid_o) begin
                wready_i <= 1'b1;
            end
            if (bvalid_i && bready_o) begin
                compare_store();
                bvalid_i <= 1'b0;
                aw_seen <= 1'b0;
                w_seen <= 1'b0;
                b_wait <= $urandom_range(4, 0);
            end else if (aw_seen && w_seen && !bvalid_i) begin
                if (b_wait == 0) begin
                    bvalid_i <= 1'b1;
                end else begin
                    b_wait <= b_wait - 1;
                end
            end
        end
    end

    initial begin
        void'($urandom(32'h1ee5_e0d6));
        rst_n_i <= 1'b0;
        arready_i <= 1'b0;
        rvalid_i <= 1'b0;
        rdata_i <= '0;
        rresp_i <= '0;
        awready_i <= 1'b0;
        wready_i <= 1'b0;
        bvalid_i <= 1'b0;
        bresp_i <= '0;
        build_program();
        run_reference();

        repeat (4) begin
            @(posedge clk_i);
            check_idle_outputs("outputs during reset");
        end
        rst_n_i <= 1'b1;
        @(posedge clk_i);
        check_idle_outputs("outputs after reset");
        check_value("arvalid after reset", 64'd1, 64'(arvalid_o));
        check_value("first fetch address", RESET_VEC, araddr_o);

        cycles = 0;
        while (!halt_o && cycles < RUN_LIMIT) begin
            @(posedge clk_i);
            cycles++;
        end
        assert (halt_o) else note_failure("timeout waiting for halt_o after ebreak");
        check_value("stores left at halt", 64'd0, 64'(exp_addr_q.size()));
        check_value("stores checked", 64'(exp_total), 64'(stores_checked));
        check_value("bready at halt", 64'd0, 64'(bready_o));

        // the read issued as ebreak was taken may still finish
        cycles = 0;
        while ((arvalid_o || rready_o) && cycles < WAIT_LIMIT) begin
            @(posedge clk_i);
            cycles++;
        end
        assert (!arvalid_o && !rready_o) else note_failure("timeout waiting for fetch to settle");
        for (int i = 0; i < 50; i++) begin
            @(posedge clk_i);
            assert (!arvalid_o) else note_failure("arvalid_o raised after halt");
        end

        $display("errors: %0d, stores checked: %0d of %0d, reads: %0d",
                 errors, stores_checked, exp_total, reads_seen);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
verilog/kiwi_pkg.sv
verilog/kiwi_if.sv
verilog/fetch_unit.sv
verilog/inst_decoder.sv
verilog/int_execute.sv
verilog/store_unit.sv
verilog/kiwi_core.sv
testbench/kiwi_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the kiwi_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module kiwi_tb -f sources.f \
    --Mdir obj_dir -o kiwi_sim

./obj_dir/kiwi_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST OK$" sim.log; then
    exit 0
fi
exit 1
